//--- hw/aggregator.sv
`timescale 1ns/1ps

module aggregator (
  input  logic                 clk,
  input  logic                 rst_n,

  output logic                 pop_o,
  input  gat_pkg::coef_entry_t entry_i,
  input  logic                 empty_i,

  output logic                 out_valid_o,
  output gat_pkg::acc_t        out_data_o,
  input  logic                 out_ready_i
);

  import gat_pkg::*;

  aggr_state_e                     state;
  acc_t                            acc_q [NUM_FEAT_OUT];
  logic [$clog2(NUM_FEAT_OUT)-1:0] emit_idx;
  logic                            out_fire;

  assign pop_o       = (state == ACCUM) && !empty_i;
  assign out_valid_o = (state == EMIT);
  assign out_data_o  = acc_q[emit_idx];
  assign out_fire    = out_valid_o && out_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= ACCUM;
      emit_idx <= '0;
      for (int f = 0; f < NUM_FEAT_OUT; f++) begin
        acc_q[f] <= '0;
      end
    end else begin
      case (state)
        ACCUM: begin
          if (pop_o) begin
            // Products wrap to 32 bits along with the sum
            for (int f = 0; f < NUM_FEAT_OUT; f++) begin
              acc_q[f] <= acc_q[f] + $signed(entry_i.coef) * $signed(entry_i.wh[f]);
            end
            if (entry_i.last) begin
              state    <= EMIT;
              emit_idx <= '0;
            end
          end
        end
        EMIT: begin
          if (out_fire) begin
            if (emit_idx == NUM_FEAT_OUT - 1) begin
              state <= ACCUM;
              for (int f = 0; f < NUM_FEAT_OUT; f++) begin
                acc_q[f] <= '0;
              end
            end else begin
              emit_idx <= emit_idx + 1'b1;
            end
          end
        end
        default: state <= ACCUM;
      endcase
    end
  end

  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("result word changed while stalled");

endmodule

//--- hw/attention_score.sv
`timescale 1ns/1ps

module attention_score (
  input  logic                 clk,
  input  logic                 rst_n,

  input  gat_pkg::att_vec_t    att_vec_i,

  input  logic                 wh_valid_i,
  input  gat_pkg::wh_row_t     wh_row_i,
  input  logic                 wh_last_i,
  output logic                 wh_ready_o,

  output logic                 push_o,
  output gat_pkg::coef_entry_t entry_o,
  input  logic                 full_i
);

  import gat_pkg::*;

  logic   first_q;
  score_t tgt_q;
  score_t tgt_now;
  score_t nbr_now;
  score_t tgt_use;
  score_t score;

  // Target and neighbor halves of a dotted with this Wh row
  always_comb begin
    tgt_now = '0;
    nbr_now = '0;
    for (int f = 0; f < NUM_FEAT_OUT; f++) begin
      tgt_now = tgt_now + $signed(att_vec_i[f]) * $signed(wh_row_i[f]);
      nbr_now = nbr_now + $signed(att_vec_i[NUM_FEAT_OUT + f]) * $signed(wh_row_i[f]);
    end
  end

  // First row of a subgraph supplies its own target term
  assign tgt_use = first_q ? tgt_now : tgt_q;
  assign score   = tgt_use + nbr_now;

  assign wh_ready_o = !full_i;
  assign push_o     = wh_valid_i && !full_i;

  assign entry_o.coef = score_to_coef(score);
  assign entry_o.wh   = wh_row_i;
  assign entry_o.last = wh_last_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q <= 1'b1;
    end else if (push_o) begin
      first_q <= wh_last_i;
    end
  end

  always_ff @(posedge clk) begin
    if (push_o && first_q) begin
      tgt_q <= tgt_now;
    end
  end

endmodule

//--- hw/gat_layer_top.sv
`timescale 1ns/1ps

module gat_layer_top (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               wgt_valid_i,
  input  gat_pkg::data_t     wgt_data_i,
  output logic               wgt_ready_o,

  input  logic               feat_valid_i,
  input  gat_pkg::feat_row_t feat_data_i,
  input  logic               feat_last_i,
  output logic               feat_ready_o,

  output logic               out_valid_o,
  output gat_pkg::acc_t      out_data_o,
  input  logic               out_ready_i
);

  import gat_pkg::*;

  wgt_mat_t    wgt_mat;
  att_vec_t    att_vec;
  logic        weights_loaded;

  logic        wh_valid;
  wh_row_t     wh_row;
  logic        wh_last;
  logic        wh_ready;

  logic        fifo_push;
  coef_entry_t fifo_wdata;
  logic        fifo_full;
  logic        fifo_pop;
  coef_entry_t fifo_rdata;
  logic        fifo_empty;

  weight_loader u_weight_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_valid_i (wgt_valid_i),
    .wgt_data_i  (wgt_data_i),
    .wgt_ready_o (wgt_ready_o),
    .wgt_mat_o   (wgt_mat),
    .att_vec_o   (att_vec),
    .loaded_o    (weights_loaded)
  );

  wh_projection u_wh_projection (
    .clk          (clk),
    .rst_n        (rst_n),
    .loaded_i     (weights_loaded),
    .wgt_mat_i    (wgt_mat),
    .feat_valid_i (feat_valid_i),
    .feat_data_i  (feat_data_i),
    .feat_last_i  (feat_last_i),
    .feat_ready_o (feat_ready_o),
    .wh_valid_o   (wh_valid),
    .wh_row_o     (wh_row),
    .wh_last_o    (wh_last),
    .wh_ready_i   (wh_ready)
  );

  attention_score u_attention_score (
    .clk        (clk),
    .rst_n      (rst_n),
    .att_vec_i  (att_vec),
    .wh_valid_i (wh_valid),
    .wh_row_i   (wh_row),
    .wh_last_i  (wh_last),
    .wh_ready_o (wh_ready),
    .push_o     (fifo_push),
    .entry_o    (fifo_wdata),
    .full_i     (fifo_full)
  );

  sync_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (fifo_push),
    .wdata_i (fifo_wdata),
    .full_o  (fifo_full),
    .pop_i   (fifo_pop),
    .rdata_o (fifo_rdata),
    .empty_o (fifo_empty)
  );

  aggregator u_aggregator (
    .clk         (clk),
    .rst_n       (rst_n),
    .pop_o       (fifo_pop),
    .entry_i     (fifo_rdata),
    .empty_i     (fifo_empty),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

endmodule

//--- hw/gat_pkg.sv
package gat_pkg;

  // Layer sizes
  localparam int NUM_FEAT_IN   = 4;
  localparam int NUM_FEAT_OUT  = 2;
  localparam int MAX_NODES     = 4;
  localparam int NUM_WGT_WORDS = NUM_FEAT_IN * NUM_FEAT_OUT + 2 * NUM_FEAT_OUT;

  // Coefficient scaling
  localparam int LRELU_SHIFT = 3;
  localparam int COEF_SHIFT  = 8;

  localparam int FIFO_DEPTH = 8;

  typedef logic signed [7:0]  data_t;
  typedef logic signed [17:0] wh_t;
  typedef logic signed [27:0] score_t;
  typedef logic signed [15:0] coef_t;
  typedef logic signed [31:0] acc_t;

  typedef data_t [NUM_FEAT_IN-1:0]                    feat_row_t;
  typedef wh_t   [NUM_FEAT_OUT-1:0]                   wh_row_t;
  typedef data_t [NUM_FEAT_IN-1:0][NUM_FEAT_OUT-1:0]  wgt_mat_t;
  // Lower half is the target part, upper half the neighbor part
  typedef data_t [2*NUM_FEAT_OUT-1:0]                 att_vec_t;

  typedef struct packed {
    coef_t   coef;
    wh_row_t wh;
    logic    last;
  } coef_entry_t;

  typedef enum logic {ACCUM, EMIT} aggr_state_e;

  localparam score_t COEF_MAX = (2 ** ($bits(coef_t) - 1)) - 1;
  localparam score_t COEF_MIN = -(2 ** ($bits(coef_t) - 1));

  // LeakyReLU, scale down, saturate to coef_t
  function automatic coef_t score_to_coef(input score_t score);
    score_t lrelu;
    score_t scaled;
    lrelu  = (score < 0) ? (score >>> LRELU_SHIFT) : score;
    scaled = lrelu >>> COEF_SHIFT;
    if (scaled > COEF_MAX) begin
      return coef_t'(COEF_MAX);
    end
    if (scaled < COEF_MIN) begin
      return coef_t'(COEF_MIN);
    end
    return coef_t'(scaled);
  endfunction

endpackage

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DEPTH = gat_pkg::FIFO_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 push_i,
  input  gat_pkg::coef_entry_t wdata_i,
  output logic                 full_o,

  input  logic                 pop_i,
  output gat_pkg::coef_entry_t rdata_o,
  output logic                 empty_o
);

  import gat_pkg::*;

  // DEPTH must be a power of two so the pointers wrap on their own
  coef_entry_t                mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;

  assign full_o  = (count == DEPTH);
  assign empty_o = (count == 0);
  assign rdata_o = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) full_o |-> !push_i)
    else $error("coefficient FIFO pushed while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) empty_o |-> !pop_i)
    else $error("coefficient FIFO popped while empty");

endmodule

//--- hw/weight_loader.sv
`timescale 1ns/1ps

module weight_loader (
  input  logic              clk,
  input  logic              rst_n,

  input  logic              wgt_valid_i,
  input  gat_pkg::data_t    wgt_data_i,
  output logic              wgt_ready_o,

  output gat_pkg::wgt_mat_t wgt_mat_o,
  output gat_pkg::att_vec_t att_vec_o,
  output logic              loaded_o
);

  import gat_pkg::*;

  logic [$clog2(NUM_WGT_WORDS)-1:0] word_cnt;
  logic                             wgt_fire;

  assign wgt_ready_o = !loaded_o;
  assign wgt_fire    = wgt_valid_i && wgt_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_cnt <= '0;
      loaded_o <= 1'b0;
    end else if (wgt_fire) begin
      word_cnt <= word_cnt + 1'b1;
      if (word_cnt == NUM_WGT_WORDS - 1) begin
        loaded_o <= 1'b1;
      end
    end
  end

  // Matrix words first, column index inner, then the attention vector
  always_ff @(posedge clk) begin
    if (wgt_fire) begin
      if (word_cnt < NUM_FEAT_IN * NUM_FEAT_OUT) begin
        wgt_mat_o[word_cnt / NUM_FEAT_OUT][word_cnt % NUM_FEAT_OUT] <= wgt_data_i;
      end else begin
        att_vec_o[word_cnt - NUM_FEAT_IN * NUM_FEAT_OUT] <= wgt_data_i;
      end
    end
  end

  a_load_once: assert property (@(posedge clk) disable iff (!rst_n)
    wgt_fire |-> word_cnt < NUM_WGT_WORDS)
    else $error("weight word accepted after load completed");

endmodule

//--- hw/wh_projection.sv
`timescale 1ns/1ps

module wh_projection (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               loaded_i,
  input  gat_pkg::wgt_mat_t  wgt_mat_i,

  input  logic               feat_valid_i,
  input  gat_pkg::feat_row_t feat_data_i,
  input  logic               feat_last_i,
  output logic               feat_ready_o,

  output logic               wh_valid_o,
  output gat_pkg::wh_row_t   wh_row_o,
  output logic               wh_last_o,
  input  logic               wh_ready_i
);

  import gat_pkg::*;

  wh_row_t wh_next;
  logic    feat_fire;

  // One dot product per output feature
  always_comb begin
    wh_t sum;
    for (int f = 0; f < NUM_FEAT_OUT; f++) begin
      sum = '0;
      for (int k = 0; k < NUM_FEAT_IN; k++) begin
        sum = sum + $signed(feat_data_i[k]) * $signed(wgt_mat_i[k][f]);
      end
      wh_next[f] = sum;
    end
  end

  assign feat_ready_o = loaded_i && (!wh_valid_o || wh_ready_i);
  assign feat_fire    = feat_valid_i && feat_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_valid_o <= 1'b0;
    end else if (feat_fire) begin
      wh_valid_o <= 1'b1;
    end else if (wh_ready_i) begin
      wh_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (feat_fire) begin
      wh_row_o  <= wh_next;
      wh_last_o <= feat_last_i;
    end
  end

endmodule

//--- project.f
hw/gat_pkg.sv
hw/weight_loader.sv
hw/wh_projection.sv
hw/attention_score.sv
hw/sync_fifo.sv
hw/aggregator.sv
hw/gat_layer_top.sv
verification/gat_checker.sv
verification/tb_gat_layer.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gat_layer \
  -f project.f -o sim_gat || { echo "build failed"; exit 1; }
./obj_dir/sim_gat > sim.log 2>&1
cat sim.log
grep -qx "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verification/gat_checker.sv
`timescale 1ns/1ps

module gat_checker (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               wgt_valid_i,
  input  gat_pkg::data_t     wgt_data_i,
  input  logic               wgt_ready_i,

  input  logic               feat_valid_i,
  input  gat_pkg::feat_row_t feat_data_i,
  input  logic               feat_last_i,
  input  logic               feat_ready_i,

  input  logic               out_valid_i,
  input  gat_pkg::acc_t      out_data_i,
  input  logic               out_ready_i,

  output int                 err_cnt_o,
  output int                 pending_o
);

  import gat_pkg::*;

  localparam int ATT_BASE = NUM_FEAT_IN * NUM_FEAT_OUT;

  int   wgt [NUM_WGT_WORDS];
  int   wgt_cnt = 0;
  int   feats [MAX_NODES][NUM_FEAT_IN];
  int   n_rows = 0;
  int   word_idx = 0;
  int   err_cnt = 0;
  acc_t expected [$];

  // LeakyReLU on the raw score, then scale and saturate to 16 bits
  function automatic longint lrelu_coef(input longint score);
    longint c;
    c = (score < 0) ? (score >>> LRELU_SHIFT) : score;
    c = c >>> COEF_SHIFT;
    if (c > 32767) begin
      c = 32767;
    end else if (c < -32768) begin
      c = -32768;
    end
    return c;
  endfunction

  // One output feature of the captured subgraph, node 0 is the target
  function automatic acc_t ref_feature(input int f);
    longint wh [MAX_NODES][NUM_FEAT_OUT];
    longint tgt;
    longint score;
    longint sum;
    tgt = 0;
    sum = 0;
    for (int j = 0; j < n_rows; j++) begin
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        wh[j][o] = 0;
        for (int k = 0; k < NUM_FEAT_IN; k++) begin
          wh[j][o] += longint'(feats[j][k]) * wgt[k * NUM_FEAT_OUT + o];
        end
      end
    end
    for (int o = 0; o < NUM_FEAT_OUT; o++) begin
      tgt += longint'(wgt[ATT_BASE + o]) * wh[0][o];
    end
    for (int j = 0; j < n_rows; j++) begin
      score = tgt;
      for (int o = 0; o < NUM_FEAT_OUT; o++) begin
        score += longint'(wgt[ATT_BASE + NUM_FEAT_OUT + o]) * wh[j][o];
      end
      sum += lrelu_coef(score) * wh[j][f];
    end
    return acc_t'(sum);
  endfunction

  always @(posedge clk or negedge rst_n) begin
    data_t v;
    acc_t  exp_word;
    if (!rst_n) begin
      wgt_cnt = 0;
      n_rows  = 0;
      expected.delete();
    end else begin
      if (wgt_valid_i && wgt_ready_i) begin
        if (wgt_cnt < NUM_WGT_WORDS) begin
          wgt[wgt_cnt] = int'(wgt_data_i);
        end else begin
          $display("weight word accepted after the load had completed at %0t", $time);
          err_cnt++;
        end
        wgt_cnt++;
      end
      if (feat_valid_i && feat_ready_i) begin
        if (n_rows < MAX_NODES) begin
          for (int k = 0; k < NUM_FEAT_IN; k++) begin
            v = feat_data_i[k];
            feats[n_rows][k] = int'(v);
          end
          n_rows++;
        end
        if (feat_last_i) begin
          for (int f = 0; f < NUM_FEAT_OUT; f++) begin
            expected.push_back(ref_feature(f));
          end
          n_rows = 0;
        end
      end
      if (out_valid_i && out_ready_i) begin
        if (expected.size() == 0) begin
          $display("error %0t: result word %0d arrived with nothing expected", $time, word_idx);
          err_cnt++;
        end else begin
          exp_word = expected.pop_front();
          if (out_data_i !== exp_word) begin
            $display("error %0t: result word %0d expected %0d got %0d",
                     $time, word_idx, exp_word, out_data_i);
            err_cnt++;
          end
        end
        word_idx++;
      end
    end
    err_cnt_o <= err_cnt;
    pending_o <= expected.size();
  end

endmodule

//--- verification/tb_gat_layer.sv
`timescale 1ns/1ps

module tb_gat_layer;

  import gat_pkg::*;

  localparam int TIMEOUT       = 1000;
  localparam int DRAIN_TIMEOUT = 4000;
  localparam int NUM_RANDOM    = 200;
  localparam int NUM_LARGE     = 40;
  localparam int NUM_STALLED   = 100;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      wgt_valid_i;
  data_t     wgt_data_i;
  logic      wgt_ready_o;
  logic      feat_valid_i;
  feat_row_t feat_data_i;
  logic      feat_last_i;
  logic      feat_ready_o;
  logic      out_valid_o;
  acc_t      out_data_o;
  logic      out_ready_i;

  logic bp_en = 1'b0;
  int   seed = 64322;
  int   tb_errors = 0;
  int   timeouts = 0;
  int   chk_errors;
  int   pending;

  gat_layer_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wgt_valid_i  (wgt_valid_i),
    .wgt_data_i   (wgt_data_i),
    .wgt_ready_o  (wgt_ready_o),
    .feat_valid_i (feat_valid_i),
    .feat_data_i  (feat_data_i),
    .feat_last_i  (feat_last_i),
    .feat_ready_o (feat_ready_o),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o),
    .out_ready_i  (out_ready_i)
  );

  gat_checker i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .wgt_valid_i  (wgt_valid_i),
    .wgt_data_i   (wgt_data_i),
    .wgt_ready_i  (wgt_ready_o),
    .feat_valid_i (feat_valid_i),
    .feat_data_i  (feat_data_i),
    .feat_last_i  (feat_last_i),
    .feat_ready_i (feat_ready_o),
    .out_valid_i  (out_valid_o),
    .out_data_i   (out_data_o),
    .out_ready_i  (out_ready_i),
    .err_cnt_o    (chk_errors),
    .pending_o    (pending)
  );

  always #5 clk = ~clk;

  // Every edge also redraws the result-side ready when stalls are on
  task automatic next_cycle();
    int r;
    @(posedge clk);
    r = $random(seed);
    out_ready_i <= bp_en ? r[0] : 1'b1;
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r >> 1) % n;
  endfunction

  function automatic data_t rand_value(input int lo, input int hi);
    int r;
    int m;
    r = $random(seed);
    m = lo + ((r >> 1) % (hi - lo + 1));
    return r[0] ? data_t'(-m) : data_t'(m);
  endfunction

  task automatic send_weight(input data_t w);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    if (timeouts != 0) begin
      return;
    end
    wgt_valid_i <= 1'b1;
    wgt_data_i  <= w;
    do begin
      next_cycle();
      waited++;
      accepted = wgt_ready_o;
      if (feat_ready_o) begin
        $display("error %0t: feat_ready_o high before the weights were loaded", $time);
        tb_errors++;
      end
    end while (!accepted && waited < TIMEOUT);
    if (!accepted) begin
      $display("timeout at %0t: a weight word was never accepted", $time);
      timeouts++;
    end
  endtask

  task automatic send_row(input feat_row_t row, input logic last);
    int   waited;
    logic accepted;
    waited   = 0;
    accepted = 1'b0;
    if (timeouts != 0) begin
      return;
    end
    feat_valid_i <= 1'b1;
    feat_data_i  <= row;
    feat_last_i  <= last;
    do begin
      next_cycle();
      waited++;
      accepted = feat_ready_o;
    end while (!accepted && waited < TIMEOUT);
    feat_valid_i <= 1'b0;
    if (!accepted) begin
      $display("timeout at %0t: a node row was never accepted", $time);
      timeouts++;
    end
  endtask

  task automatic send_subgraph(input int n, input int lo, input int hi);
    feat_row_t row;
    for (int j = 0; j < n; j++) begin
      for (int k = 0; k < NUM_FEAT_IN; k++) begin
        row[k] = rand_value(lo, hi);
      end
      send_row(row, j == n - 1);
    end
  endtask

  initial begin
    int waited;
    rst_n        = 1'b0;
    wgt_valid_i  = 1'b0;
    wgt_data_i   = '0;
    feat_valid_i = 1'b0;
    feat_data_i  = '0;
    feat_last_i  = 1'b0;
    out_ready_i  = 1'b1;
    repeat (3) next_cycle();
    rst_n <= 1'b1;

    for (int i = 0; i < NUM_WGT_WORDS; i++) begin
      send_weight(rand_value(64, 127));
    end
    // Valid stays up, ready must stay down
    repeat (4) begin
      next_cycle();
      if (wgt_ready_o) begin
        $display("error %0t: wgt_ready_o high after %0d words", $time, NUM_WGT_WORDS);
        tb_errors++;
      end
    end
    wgt_valid_i <= 1'b0;

    send_row({8'sd12, -8'sd7, 8'sd3, 8'sd9}, 1'b1);
    for (int s = 0; s < NUM_RANDOM; s++) begin
      send_subgraph(1 + rand_below(MAX_NODES), 0, 16);
    end
    for (int s = 0; s < NUM_LARGE; s++) begin
      send_subgraph(1 + rand_below(MAX_NODES), 96, 127);
    end

    bp_en = 1'b1;
    for (int s = 0; s < NUM_STALLED; s++) begin
      send_subgraph(1 + rand_below(MAX_NODES), 0, s[0] ? 127 : 16);
    end

    waited = 0;
    do begin
      next_cycle();
      waited++;
    end while (pending != 0 && waited < DRAIN_TIMEOUT);
    if (pending != 0) begin
      $display("timeout at %0t: %0d expected result words never arrived", $time, pending);
      timeouts++;
    end
    repeat (5) next_cycle();

    $display("summary: %0d testbench errors, %0d checker errors, %0d timeouts",
             tb_errors, chk_errors, timeouts);
    if (tb_errors == 0 && chk_errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
